//--- include/splitter_settings.svh
/*
 * build-time settings of the write-burst splitter
 * page size, bus width, address and length widths, queue depth
 */

`ifndef SPLITTER_SETTINGS_SVH
`define SPLITTER_SETTINGS_SVH

// ------------------------------------------------------------
// bus geometry
// ------------------------------------------------------------

// bursts never cross this boundary
`define SPLIT_PAGE_SIZE    4096
// data bus word in bytes
`define SPLIT_BUS_BYTES    16

// ------------------------------------------------------------
// request fields and buffering
// ------------------------------------------------------------
`define SPLIT_ADDR_W       64
`define SPLIT_LEN_W        14
// segment-control entries between address and data side
`define SPLIT_QUEUE_DEPTH  32

`endif

//--- logic/splitter_pkg.sv
/*
 * splitter types: address, length, bus word, beat count,
 * write request and segment-control item
 */

`include "splitter_settings.svh"

package splitter_pkg;

    // ------------------------------------------------------------
    // scalar fields
    // ------------------------------------------------------------
    typedef logic [`SPLIT_ADDR_W-1:0] addr_t;

    // byte length of a request or a segment
    typedef logic [`SPLIT_LEN_W-1:0] len_t;

    // one bus word
    typedef logic [8*`SPLIT_BUS_BYTES-1:0] data_t;

    // bus words in one segment, up to a full page
    typedef logic [$clog2(`SPLIT_PAGE_SIZE/`SPLIT_BUS_BYTES+1)-1:0] beat_cnt_t;

    // ------------------------------------------------------------
    // channel payloads
    // ------------------------------------------------------------

    // write request, payload of the address slice
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } addr_req_t;

    // one entry per emitted segment
    typedef struct packed {
        beat_cnt_t beats;
    } seg_ctrl_t;

endpackage

//--- logic/reg_slice.sv
/*
 * valid/ready register slice, two entries
 * main and spare register, registered ready, full throughput
 */

`timescale 1ns/10ps

module reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     src_valid,
    output logic     src_ready,
    input  payload_t src,
    output logic     dst_valid,
    input  logic     dst_ready,
    output payload_t dst
);

    logic     main_valid;
    logic     spare_valid;
    payload_t main_q;
    payload_t spare_q;

    logic src_fire;
    logic load_main;
    logic main_valid_n;
    logic spare_valid_n;

    // src_ready is low whenever the spare holds an item
    assign src_fire  = src_valid && src_ready;
    // main may take a new item when empty or draining
    assign load_main = !main_valid || dst_ready;

    // ------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------
    always_comb begin
        if (load_main) begin
            // spare item moves up before any incoming one
            main_valid_n  = spare_valid || src_fire;
            spare_valid_n = 1'b0;
        end else begin
            // incoming item parks in spare while main is stalled
            main_valid_n  = 1'b1;
            spare_valid_n = spare_valid || src_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
            src_ready   <= 1'b0;
        end else begin
            main_valid  <= main_valid_n;
            spare_valid <= spare_valid_n;
            src_ready   <= !spare_valid_n;
        end
    end

    // ------------------------------------------------------------
    // payload registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load_main) begin
            main_q <= spare_valid ? spare_q : src;
        end
        if (!load_main && src_fire) begin
            spare_q <= src;
        end
    end

    assign dst_valid = main_valid;
    assign dst       = main_q;

endmodule

//--- logic/page_segmenter.sv
/*
 * address-channel FSM of the write splitter
 * cuts each request into segments that stay inside one page
 * and queues the beat count of every segment
 */

`timescale 1ns/10ps

`include "splitter_settings.svh"

module page_segmenter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  splitter_pkg::addr_req_t req,
    input  logic                   out_aready,
    output logic                   out_avalid,
    output splitter_pkg::addr_t    out_addr,
    output splitter_pkg::len_t     out_len,
    input  logic                   q_full,
    output logic                   q_push,
    output splitter_pkg::seg_ctrl_t q_item
);

    localparam int page_bytes = `SPLIT_PAGE_SIZE;
    localparam int page_bits  = $clog2(page_bytes);
    localparam int bus_bits   = $clog2(`SPLIT_BUS_BYTES);

    typedef enum logic {
        s_idle,
        s_segmenting
    } seg_state_t;

    seg_state_t state;

    // start of the next segment and bytes still to go
    splitter_pkg::addr_t next_addr;
    splitter_pkg::len_t  resid;

    splitter_pkg::addr_t cur_addr;
    splitter_pkg::len_t  cur_rest;
    splitter_pkg::len_t  room;
    splitter_pkg::len_t  cur_len;
    splitter_pkg::len_t  len_round_up;
    logic                fits;
    logic                can_emit;
    logic                emit;

    // ------------------------------------------------------------
    // current segment
    // ------------------------------------------------------------
    always_comb begin
        // downstream grant and space for the control item
        can_emit = out_aready && !q_full;

        if (state == s_idle) begin
            // fresh request straight from the slice
            cur_addr = req.addr;
            cur_rest = req.len;
            emit     = req_valid && can_emit;
        end else begin
            // slice still holds the request
            cur_addr = next_addr;
            cur_rest = resid;
            emit     = can_emit;
        end

        // bytes up to the page boundary or a whole page once aligned
        room    = splitter_pkg::len_t'(page_bytes)
                - splitter_pkg::len_t'(cur_addr[page_bits-1:0]);
        fits    = (cur_rest <= room);
        cur_len = fits ? cur_rest : room;

        // segment length in bus words, rounded up
        len_round_up = cur_len + splitter_pkg::len_t'(`SPLIT_BUS_BYTES - 1);
    end

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------

    // out_avalid is a strobe and never held
    assign out_avalid = emit;
    assign out_addr   = cur_addr;
    assign out_len    = cur_len;

    assign q_push       = emit;
    assign q_item.beats = splitter_pkg::beat_cnt_t'(len_round_up >> bus_bits);

    // request retires with its final segment
    assign req_ready = emit && fits;

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else if (emit) begin
            state <= fits ? s_idle : s_segmenting;
        end
    end

    // start and residual length of the next segment
    always_ff @(posedge clk) begin
        if (emit && !fits) begin
            next_addr <= cur_addr + splitter_pkg::addr_t'(cur_len);
            resid     <= cur_rest - cur_len;
        end
    end

endmodule

//--- logic/seg_queue.sv
/*
 * synchronous FIFO of segment-control items
 * circular buffer with read and write pointers and a fill count
 */

`timescale 1ns/10ps

`include "splitter_settings.svh"

module seg_queue #(
    parameter int depth = `SPLIT_QUEUE_DEPTH
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  splitter_pkg::seg_ctrl_t item_in,
    output logic                    full,
    input  logic                    pop,
    output splitter_pkg::seg_ctrl_t head,
    output logic                    empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    splitter_pkg::seg_ctrl_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    logic do_push;
    logic do_pop;

    // overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    // item storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= item_in;
        end
    end

    // pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/beat_framer.sv
/*
 * data-channel framer of the write splitter
 * passes beats once their segment is queued, marks segment ends
 */

`timescale 1ns/10ps

module beat_framer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    beat_valid,
    output logic                    beat_ready,
    input  splitter_pkg::data_t     beat_data,
    input  logic                    q_empty,
    input  splitter_pkg::seg_ctrl_t q_head,
    output logic                    q_pop,
    output logic                    out_dvalid,
    input  logic                    out_dready,
    output splitter_pkg::data_t     out_data,
    output logic                    out_dlast
);

    // set after the first beat of a segment has gone out
    logic                      running;
    // beats left in the current segment
    splitter_pkg::beat_cnt_t   beats_left;

    splitter_pkg::beat_cnt_t   cur_left;
    logic                      xfer;

    // ------------------------------------------------------------
    // beat gating
    // ------------------------------------------------------------

    // no segment queued, no beat
    assign out_dvalid = beat_valid && !q_empty;
    assign beat_ready = out_dready && !q_empty;
    assign out_data   = beat_data;

    // first beat takes its count from the queue head
    assign cur_left  = running ? beats_left : q_head.beats;
    assign out_dlast = (cur_left == splitter_pkg::beat_cnt_t'(1));

    assign xfer = out_dvalid && out_dready;

    // control item retires with the last beat
    assign q_pop = xfer && out_dlast;

    // ------------------------------------------------------------
    // segment countdown
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else if (xfer) begin
            running <= !out_dlast;
        end
    end

    // one beat less after each transfer
    always_ff @(posedge clk) begin
        if (xfer) begin
            beats_left <= cur_left - 1'b1;
        end
    end

endmodule

//--- logic/wr_splitter.sv
/*
 * write-burst splitter top level
 * address and data slices, page segmenter, segment queue, beat framer
 */

`timescale 1ns/10ps

`include "splitter_settings.svh"

module wr_splitter (
    input  logic                clk,
    input  logic                reset,
    // write request in
    input  logic                in_avalid,
    output logic                in_aready,
    input  splitter_pkg::addr_t in_addr,
    input  splitter_pkg::len_t  in_len,
    // segment requests out
    output logic                out_avalid,
    input  logic                out_aready,
    output splitter_pkg::addr_t out_addr,
    output splitter_pkg::len_t  out_len,
    // data in
    input  logic                in_dvalid,
    output logic                in_dready,
    input  splitter_pkg::data_t in_data,
    // data out
    output logic                out_dvalid,
    input  logic                out_dready,
    output splitter_pkg::data_t out_data,
    output logic                out_dlast
);

    // request side between slice and segmenter
    logic                    req_valid;
    logic                    req_ready;
    splitter_pkg::addr_req_t req;

    // data side between slice and framer
    logic                    beat_valid;
    logic                    beat_ready;
    splitter_pkg::data_t     beat_data;

    // segment-control queue
    logic                    q_push;
    logic                    q_pop;
    logic                    q_full;
    logic                    q_empty;
    splitter_pkg::seg_ctrl_t q_item;
    splitter_pkg::seg_ctrl_t q_head;

    // ------------------------------------------------------------
    // address path
    // ------------------------------------------------------------
    reg_slice #(
        .payload_t (splitter_pkg::addr_req_t)
    ) i_addr_slice (
        .clk       (clk),
        .reset     (reset),
        .src_valid (in_avalid),
        .src_ready (in_aready),
        .src       ({in_addr, in_len}),
        .dst_valid (req_valid),
        .dst_ready (req_ready),
        .dst       (req)
    );

    page_segmenter i_page_segmenter (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .out_aready (out_aready),
        .out_avalid (out_avalid),
        .out_addr   (out_addr),
        .out_len    (out_len),
        .q_full     (q_full),
        .q_push     (q_push),
        .q_item     (q_item)
    );

    // links address side to data side
    seg_queue #(
        .depth (`SPLIT_QUEUE_DEPTH)
    ) i_seg_queue (
        .clk     (clk),
        .reset   (reset),
        .push    (q_push),
        .item_in (q_item),
        .full    (q_full),
        .pop     (q_pop),
        .head    (q_head),
        .empty   (q_empty)
    );

    // ------------------------------------------------------------
    // data path
    // ------------------------------------------------------------
    reg_slice #(
        .payload_t (splitter_pkg::data_t)
    ) i_data_slice (
        .clk       (clk),
        .reset     (reset),
        .src_valid (in_dvalid),
        .src_ready (in_dready),
        .src       (in_data),
        .dst_valid (beat_valid),
        .dst_ready (beat_ready),
        .dst       (beat_data)
    );

    beat_framer i_beat_framer (
        .clk        (clk),
        .reset      (reset),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat_data  (beat_data),
        .q_empty    (q_empty),
        .q_head     (q_head),
        .q_pop      (q_pop),
        .out_dvalid (out_dvalid),
        .out_dready (out_dready),
        .out_data   (out_data),
        .out_dlast  (out_dlast)
    );

endmodule

//--- sim/tb_wr_splitter.sv
/*
 * testbench of the write-burst splitter
 * request and data drivers, page-rule reference model, assertions
 */

`timescale 1ns/10ps

`include "splitter_settings.svh"

module tb_wr_splitter;

    localparam int page_bytes  = `SPLIT_PAGE_SIZE;
    localparam int bus_bytes   = `SPLIT_BUS_BYTES;
    localparam int wait_limit  = 4000;
    localparam int drain_limit = 20000;
    localparam int n_random    = 40;

    logic                clk;
    logic                reset;
    logic                in_avalid;
    logic                in_aready;
    splitter_pkg::addr_t in_addr;
    splitter_pkg::len_t  in_len;
    logic                out_avalid;
    logic                out_aready;
    splitter_pkg::addr_t out_addr;
    splitter_pkg::len_t  out_len;
    logic                in_dvalid;
    logic                in_dready;
    splitter_pkg::data_t in_data;
    logic                out_dvalid;
    logic                out_dready;
    splitter_pkg::data_t out_data;
    logic                out_dlast;

    integer seed;
    int     mismatch_count;
    int     problem_count;

    // stimulus list
    splitter_pkg::addr_t req_addr [$];
    splitter_pkg::len_t  req_len [$];

    // expected segments and beat counts, in emission order
    splitter_pkg::addr_t exp_addr_q [$];
    splitter_pkg::len_t  exp_len_q [$];
    int                  exp_beats_q [$];

    int                  tag_sent;
    int                  tag_seen;
    int                  seg_beats;
    splitter_pkg::addr_t e_addr;
    splitter_pkg::len_t  e_len;
    int                  e_beats;

    wr_splitter i_wr_splitter (
        .clk        (clk),
        .reset      (reset),
        .in_avalid  (in_avalid),
        .in_aready  (in_aready),
        .in_addr    (in_addr),
        .in_len     (in_len),
        .out_avalid (out_avalid),
        .out_aready (out_aready),
        .out_addr   (out_addr),
        .out_len    (out_len),
        .in_dvalid  (in_dvalid),
        .in_dready  (in_dready),
        .in_data    (in_data),
        .out_dvalid (out_dvalid),
        .out_dready (out_dready),
        .out_data   (out_data),
        .out_dlast  (out_dlast)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------
    task automatic flag_mismatch(input string msg);
        mismatch_count++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic raise_problem(input string msg);
        problem_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // beat tag repeated across the bus word
    function automatic splitter_pkg::data_t beat_value(input int n);
        return {(8 * bus_bytes / 32){n}};
    endfunction

    // ------------------------------------------------------------
    // page-rule reference model
    // ------------------------------------------------------------
    task automatic expect_segments(input splitter_pkg::addr_t a, input splitter_pkg::len_t l);
        splitter_pkg::addr_t cur;
        int                  rest;
        int                  room;
        int                  seg;
        cur  = a;
        rest = int'(l);
        while (rest > 0) begin
            // first cut at the page boundary, then whole pages
            room = page_bytes - int'(cur % splitter_pkg::addr_t'(page_bytes));
            seg  = (rest < room) ? rest : room;
            exp_addr_q.push_back(cur);
            exp_len_q.push_back(splitter_pkg::len_t'(seg));
            exp_beats_q.push_back((seg + bus_bytes - 1) / bus_bytes);
            cur  = cur + splitter_pkg::addr_t'(seg);
            rest = rest - seg;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic build_requests();
        logic [31:0] hi;
        logic [31:0] lo;
        int unsigned r;
        splitter_pkg::addr_t a;
        // directed requests that fit, end on a page boundary, cut once,
        // fill one page, cut many times and carry one byte
        req_addr = '{64'h2000, 64'h2ff0, 64'h3f80, 64'h4000, 64'h5010, 64'h7000};
        req_len  = '{14'd256, 14'd16, 14'd200, 14'd4096, 14'd12000, 14'd1};
        for (int i = 0; i < n_random; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            a  = {hi, lo};
            // bus-word aligned start
            a[3:0] = 4'h0;
            r = $random(seed);
            req_addr.push_back(a);
            if ((i % 4) == 0) begin
                req_len.push_back(splitter_pkg::len_t'((r & 32'h7fff_ffff) % 256 + 1));
            end else begin
                req_len.push_back(splitter_pkg::len_t'((r & 32'h7fff_ffff) % 12000 + 1));
            end
        end
    endtask

    task automatic send_request(input splitter_pkg::addr_t a, input splitter_pkg::len_t l);
        int waited;
        waited    = 0;
        in_avalid = 1'b1;
        in_addr   = a;
        in_len    = l;
        // ready is registered, so its value here holds until the edge
        while (!in_aready && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!in_aready) begin
            raise_problem("timed out waiting for the request channel to accept");
            in_avalid = 1'b0;
        end else begin
            expect_segments(a, l);
            @(posedge clk);
            #1;
            in_avalid = 1'b0;
        end
    endtask

    task automatic drive_requests();
        for (int i = 0; i < req_addr.size(); i++) begin
            send_request(req_addr[i], req_len[i]);
        end
    endtask

    task automatic drive_data();
        int beats;
        int waited;
        for (int i = 0; i < req_len.size(); i++) begin
            beats = (int'(req_len[i]) + bus_bytes - 1) / bus_bytes;
            for (int b = 0; b < beats; b++) begin
                // occasional idle cycle on the input
                if (($random(seed) & 7) == 0) begin
                    in_dvalid = 1'b0;
                    @(posedge clk);
                    #1;
                end
                in_dvalid = 1'b1;
                in_data   = beat_value(tag_sent);
                waited    = 0;
                while (!in_dready && waited < wait_limit) begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
                if (!in_dready) begin
                    raise_problem("timed out waiting for the data channel to accept");
                    in_dvalid = 1'b0;
                    return;
                end
                @(posedge clk);
                #1;
                tag_sent++;
            end
        end
        in_dvalid = 1'b0;
    endtask

    // random downstream stalls in about one cycle of four
    always begin
        @(posedge clk);
        #1;
        out_aready = (($random(seed) & 3) != 0);
        out_dready = (($random(seed) & 3) != 0);
    end

    // ------------------------------------------------------------
    // monitors
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset && out_avalid) begin
            if (exp_addr_q.size() == 0) begin
                raise_problem("segment strobe with no segment expected");
            end else begin
                e_addr = exp_addr_q.pop_front();
                e_len  = exp_len_q.pop_front();
                assert (out_addr == e_addr && out_len == e_len)
                else flag_mismatch($sformatf("segment %h+%0d, expected %h+%0d",
                                             out_addr, out_len, e_addr, e_len));
            end
        end
        if (!reset && out_dvalid && out_dready) begin
            assert (out_data == beat_value(tag_seen))
            else flag_mismatch($sformatf("beat data %h, expected tag %0d", out_data, tag_seen));
            tag_seen++;
            seg_beats++;
            if (out_dlast) begin
                if (exp_beats_q.size() == 0) begin
                    raise_problem("last beat with no segment expected");
                end else begin
                    e_beats = exp_beats_q.pop_front();
                    assert (seg_beats == e_beats)
                    else flag_mismatch($sformatf("segment of %0d beats, expected %0d",
                                                 seg_beats, e_beats));
                end
                seg_beats = 0;
            end
        end
    end

    // held output while stalled
    a_dout_stable: assert property (@(posedge clk) disable iff (reset)
        (out_dvalid && !out_dready) |=> (out_dvalid && $stable(out_data) && $stable(out_dlast)))
    else flag_mismatch("data output changed while stalled");

    a_no_strobe: assert property (@(posedge clk) disable iff (reset)
        !out_aready |-> !out_avalid)
    else flag_mismatch("segment strobe while out_aready low");

    // segment stays inside its page
    a_in_page: assert property (@(posedge clk) disable iff (reset)
        out_avalid |-> (out_len != 0 && int'(out_addr[11:0]) + int'(out_len) <= page_bytes))
    else flag_mismatch("segment crosses a page or is empty");

    a_reset_quiet: assert property (@(posedge clk)
        ($past(reset) && !reset) |-> (!out_avalid && !out_dvalid && !in_aready && !in_dready))
    else flag_mismatch("outputs active in the first cycle after reset");

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------
    initial begin
        int waited;
        clk            = 1'b0;
        reset          = 1'b1;
        in_avalid      = 1'b0;
        in_addr        = '0;
        in_len         = '0;
        in_dvalid      = 1'b0;
        in_data        = '0;
        out_aready     = 1'b0;
        out_dready     = 1'b0;
        seed           = 32'h1a276d84;
        mismatch_count = 0;
        problem_count  = 0;
        tag_sent       = 0;
        tag_seen       = 0;
        seg_beats      = 0;
        build_requests();

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        fork
            drive_requests();
            drive_data();
        join

        // drain what is still in flight
        waited = 0;
        while ((exp_addr_q.size() != 0 || exp_beats_q.size() != 0 || tag_seen != tag_sent)
               && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_addr_q.size() != 0 || exp_beats_q.size() != 0 || tag_seen != tag_sent) begin
            raise_problem("timed out waiting for segments and beats to drain");
        end
        if (seg_beats != 0) begin
            raise_problem("beats left over after the last segment end");
        end

        $display("errors: %0d value mismatches, %0d other, %0d beats checked",
                 mismatch_count, problem_count, tag_seen);
        if (mismatch_count == 0 && problem_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
logic/splitter_pkg.sv
logic/reg_slice.sv
logic/page_segmenter.sv
logic/seg_queue.sv
logic/beat_framer.sv
logic/wr_splitter.sv
sim/tb_wr_splitter.sv

//--- Makefile
# Verilator build and run of the write-burst splitter testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_wr_splitter
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
PASS_LINE ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench, run it, fail unless it reports a pass"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_LINE"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_LINE)'

clean:
	rm -rf $(BUILD_DIR)
